//--- include/router_params.svh
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// Flit kind code width.
`define ROUTER_FLIT_ID_W 3

// Packet length, also the hold limit in cycles.
`define ROUTER_LENGTH_W 12

`define ROUTER_DATA_W 32

// Local, North, East, West, South.
`define ROUTER_NUM_PORTS 5

`endif

//--- verilog/routerPkg.sv
`default_nettype none

`include "router_params.svh"

package routerPkg;

  // One-hot grant state; bit 0 is idle, bits 1 to 5 the ports.
  typedef enum logic [`ROUTER_NUM_PORTS:0] {
    GRANT_IDLE  = 6'b000001,
    GRANT_LOCAL = 6'b000010,
    GRANT_NORTH = 6'b000100,
    GRANT_EAST  = 6'b001000,
    GRANT_WEST  = 6'b010000,
    GRANT_SOUTH = 6'b100000
  } grantState_e;

  typedef enum logic [`ROUTER_FLIT_ID_W-1:0] {
    FLIT_HEADER = 3'b001, // Carries the packet length.
    FLIT_BODY   = 3'b010,
    FLIT_TAIL   = 3'b100
  } flitKind_e;

endpackage

`default_nettype wire

//--- verilog/timerIf.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

interface timerIf;
  logic [`ROUTER_FLIT_ID_W-1:0] flitId;
  logic [`ROUTER_LENGTH_W-1:0] length;
  logic runTimer; // Port is being held.
  logic timesUp;

  modport arb (
    input  flitId, length, timesUp,
    output runTimer
  );

  modport tmr (
    input  flitId, length, runTimer,
    output timesUp
  );
endinterface

`default_nettype wire

//--- verilog/packetTimer.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

// Hold timer for one input port.
module packetTimer (
  input logic clk,
  input logic rst,
  timerIf.tmr tmr
);

  logic [`ROUTER_LENGTH_W-1:0] limit;
  logic [`ROUTER_LENGTH_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Every header flit reloads the limit.
      if (tmr.flitId == routerPkg::FLIT_HEADER)
      begin
        limit <= tmr.length;
      end

      if (tmr.runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // Idle ports restart from zero.
      end
    end
  end

  // Zero limit expires on the first held cycle.
  assign tmr.timesUp = (count == limit);

endmodule

`default_nettype wire

//--- verilog/outputArbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

// Rotating-priority grant FSM with timed hold.
module outputArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`ROUTER_NUM_PORTS-1:0] req,
  timerIf.arb                         lTimer,
  timerIf.arb                         nTimer,
  timerIf.arb                         eTimer,
  timerIf.arb                         wTimer,
  timerIf.arb                         sTimer,
  output routerPkg::grantState_e      grantState
);

  routerPkg::grantState_e nextState;

  logic [`ROUTER_NUM_PORTS-1:0] timesUp;
  logic [`ROUTER_NUM_PORTS-1:0] runTimer;
  logic [`ROUTER_NUM_PORTS-1:0] held;
  logic                         isIdle;
  int                           curPort;

  // Port order is Local, North, East, West, South.
  assign timesUp = {sTimer.timesUp, wTimer.timesUp, eTimer.timesUp,
                    nTimer.timesUp, lTimer.timesUp};

  assign lTimer.runTimer = runTimer[0];
  assign nTimer.runTimer = runTimer[1];
  assign eTimer.runTimer = runTimer[2];
  assign wTimer.runTimer = runTimer[3];
  assign sTimer.runTimer = runTimer[4];

  // Decode the current port; illegal encodings behave as idle.
  always_comb
  begin
    isIdle  = 1'b0;
    curPort = 0;
    case (grantState)
      routerPkg::GRANT_LOCAL: curPort = 0;
      routerPkg::GRANT_NORTH: curPort = 1;
      routerPkg::GRANT_EAST:  curPort = 2;
      routerPkg::GRANT_WEST:  curPort = 3;
      routerPkg::GRANT_SOUTH: curPort = 4;
      default:
      begin
        isIdle  = 1'b1;
        curPort = `ROUTER_NUM_PORTS - 1; // Search then starts at Local.
      end
    endcase
  end

  always_comb
  begin
    held = '0;
    if (!isIdle)
    begin
      held[curPort] = 1'b1;
    end
  end

  // Held port keeps running while it still requests and has time left.
  assign runTimer = held & req & ~timesUp;

  always_comb
  begin
    int                         idx;
    logic                       found;
    logic [`ROUTER_NUM_PORTS:0] oneHot;
    idx       = 0;
    found     = 1'b0;
    oneHot    = '0;
    nextState = routerPkg::GRANT_IDLE;
    if (|runTimer)
    begin
      nextState = grantState;
    end
    else
    begin
      // First requester after the current port; itself only from idle.
      for (int k = 1; k <= `ROUTER_NUM_PORTS; k++)
      begin
        idx = (curPort + k) % `ROUTER_NUM_PORTS;
        if (!found && req[idx] && (isIdle || idx != curPort))
        begin
          found       = 1'b1;
          oneHot      = '0;
          oneHot[idx + 1] = 1'b1;
          nextState   = routerPkg::grantState_e'(oneHot);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantState <= routerPkg::GRANT_IDLE;
    end
    else
    begin
      grantState <= nextState;
    end
  end

endmodule

`default_nettype wire

//--- verilog/flitSwitch.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

// Registered five-to-one data mux.
module flitSwitch (
  input  logic                                          clk,
  input  logic                                          rst,
  input  routerPkg::grantState_e                        grantState,
  input  logic [`ROUTER_NUM_PORTS-1:0]                  req,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_DATA_W-1:0] data,
  output logic [`ROUTER_DATA_W-1:0]                     outData,
  output logic                                          outValid
);

  logic [`ROUTER_DATA_W-1:0] selData;
  logic                      selValid;

  always_comb
  begin
    selData  = '0; // Idle drives zero.
    selValid = 1'b0;
    case (grantState)
      routerPkg::GRANT_LOCAL:
      begin
        selData  = data[0];
        selValid = req[0];
      end
      routerPkg::GRANT_NORTH:
      begin
        selData  = data[1];
        selValid = req[1];
      end
      routerPkg::GRANT_EAST:
      begin
        selData  = data[2];
        selValid = req[2];
      end
      routerPkg::GRANT_WEST:
      begin
        selData  = data[3];
        selValid = req[3];
      end
      routerPkg::GRANT_SOUTH:
      begin
        selData  = data[4];
        selValid = req[4];
      end
      default:
      begin
        selData  = '0;
        selValid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    outData <= selData;
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

endmodule

`default_nettype wire

//--- verilog/routerOutputPort.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

// One output port of the mesh router.
module routerOutputPort (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [`ROUTER_NUM_PORTS-1:0]                   req,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_ID_W-1:0] flitId,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_LENGTH_W-1:0]  length,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_DATA_W-1:0]    data,
  output logic [`ROUTER_NUM_PORTS-1:0]                   grant,
  output logic [`ROUTER_DATA_W-1:0]                      outData,
  output logic                                           outValid
);

  routerPkg::grantState_e grantState;

  timerIf lIf ();
  timerIf nIf ();
  timerIf eIf ();
  timerIf wIf ();
  timerIf sIf ();

  assign lIf.flitId = flitId[0];
  assign lIf.length = length[0];
  assign nIf.flitId = flitId[1];
  assign nIf.length = length[1];
  assign eIf.flitId = flitId[2];
  assign eIf.length = length[2];
  assign wIf.flitId = flitId[3];
  assign wIf.length = length[3];
  assign sIf.flitId = flitId[4];
  assign sIf.length = length[4];

  packetTimer i_lTimer (
    .clk (clk),
    .rst (rst),
    .tmr (lIf)
  );

  packetTimer i_nTimer (
    .clk (clk),
    .rst (rst),
    .tmr (nIf)
  );

  packetTimer i_eTimer (
    .clk (clk),
    .rst (rst),
    .tmr (eIf)
  );

  packetTimer i_wTimer (
    .clk (clk),
    .rst (rst),
    .tmr (wIf)
  );

  packetTimer i_sTimer (
    .clk (clk),
    .rst (rst),
    .tmr (sIf)
  );

  outputArbiter i_arbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .lTimer     (lIf),
    .nTimer     (nIf),
    .eTimer     (eIf),
    .wTimer     (wIf),
    .sTimer     (sIf),
    .grantState (grantState)
  );

  flitSwitch i_switch (
    .clk        (clk),
    .rst        (rst),
    .grantState (grantState),
    .req        (req),
    .data       (data),
    .outData    (outData),
    .outValid   (outValid)
  );

  assign grant = grantState[`ROUTER_NUM_PORTS:1]; // Drop the idle bit.

endmodule

`default_nettype wire

//--- bench/routerOutputPortTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

module routerOutputPortTb;

  localparam int RANDOM_CYCLES  = 4000;
  localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 1000; // Directed part is a few hundred.
  localparam int GRANT_WAIT     = 40;
  localparam int LEN_W          = `ROUTER_LENGTH_W;

  logic                                                clk;
  logic                                                rst;
  logic [`ROUTER_NUM_PORTS-1:0]                        req;
  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_ID_W-1:0] flitId;
  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_LENGTH_W-1:0]  length;
  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_DATA_W-1:0]    data;
  logic [`ROUTER_NUM_PORTS-1:0]                        grant;
  logic [`ROUTER_DATA_W-1:0]                           outData;
  logic                                                outValid;

  // Reference model; mPort is -1 while idle.
  int                           mPort;
  logic [`ROUTER_LENGTH_W-1:0]  mLimit [`ROUTER_NUM_PORTS];
  logic [`ROUTER_LENGTH_W-1:0]  mCount [`ROUTER_NUM_PORTS];
  logic [`ROUTER_NUM_PORTS-1:0] expGrant;
  logic [`ROUTER_DATA_W-1:0]    expData;
  logic                         expValid;

  int          dirLimit [`ROUTER_NUM_PORTS];
  logic [31:0] rngState;
  int          errors = 0;
  int          checks = 0;
  int          cycleCount = 0;

  routerOutputPort i_dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .length   (length),
    .data     (data),
    .grant    (grant),
    .outData  (outData),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic logic [`ROUTER_NUM_PORTS-1:0] portBit(input int p);
    logic [`ROUTER_NUM_PORTS-1:0] b;
    b    = '0;
    b[p] = 1'b1;
    return b;
  endfunction

  // Model steps on the same edge as the DUT, from the inputs before the edge.
  always @(posedge clk)
  begin
    int                           nextPort;
    int                           idx;
    logic [`ROUTER_NUM_PORTS-1:0] run;
    nextPort = -1;
    run      = '0;
    expData  = '0;
    expValid = 1'b0;
    if (rst)
    begin
      mPort = -1;
      for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
      begin
        mLimit[p] = '0;
        mCount[p] = '0;
      end
    end
    else
    begin
      if (mPort >= 0)
      begin
        expData    = data[mPort];
        expValid   = req[mPort];
        run[mPort] = req[mPort] && (mCount[mPort] != mLimit[mPort]);
      end
      if (run != '0)
        nextPort = mPort;
      else if (mPort < 0)
      begin
        for (int p = `ROUTER_NUM_PORTS - 1; p >= 0; p--)
          if (req[p]) nextPort = p; // Lowest index wins, Local first.
      end
      else
      begin
        // Nearest requester after the current port wins.
        for (int k = `ROUTER_NUM_PORTS - 1; k >= 1; k--)
        begin
          idx = (mPort + k) % `ROUTER_NUM_PORTS;
          if (req[idx]) nextPort = idx;
        end
      end
      for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
      begin
        if (flitId[p] == routerPkg::FLIT_HEADER) mLimit[p] = length[p];
        mCount[p] = run[p] ? mCount[p] + 1'b1 : '0;
      end
      mPort = nextPort;
    end
    expGrant = (mPort >= 0) ? portBit(mPort) : '0;
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      checks = checks + 3;
      assert (grant == expGrant)
      else
      begin
        errors++;
        $display("Error at %0t: grant %b, expected %b", $time, grant, expGrant);
      end
      assert (outData == expData)
      else
      begin
        errors++;
        $display("Error at %0t: outData %h, expected %h", $time, outData, expData);
      end
      assert (outValid == expValid)
      else
      begin
        errors++;
        $display("Error at %0t: outValid %b, expected %b", $time, outValid, expValid);
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  task automatic nextCycle();
    @(posedge clk);
    for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
    begin
      data[p] <= nextRandom();
    end
  endtask

  // Called at a negedge; returns at the first negedge after the grant run.
  task automatic measureHold(input int port, output int cycles);
    int waitCount;
    waitCount = 0;
    cycles    = 0;
    while (grant != portBit(port) && waitCount < GRANT_WAIT)
    begin
      waitCount++;
      @(negedge clk);
    end
    checks++;
    assert (waitCount < GRANT_WAIT)
    else
    begin
      errors++;
      $display("Port %0d was never granted while it requested", port);
    end
    while (waitCount < GRANT_WAIT && grant == portBit(port))
    begin
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic checkCycles(input int port, input int cycles, input int limit);
    checks++;
    assert (cycles == limit + 1)
    else
    begin
      errors++;
      $display("Error at %0t: port %0d held %0d cycles, expected %0d",
               $time, port, cycles, limit + 1);
    end
  endtask

  task automatic checkResetAndPriority();
    repeat (3)
    begin
      @(negedge clk);
      checks++;
      assert (grant == '0 && !outValid)
      else
      begin
        errors++;
        $display("Error at %0t: grant %b outValid %b with no request", $time, grant, outValid);
      end
    end
    nextCycle();
    req <= portBit(2) | portBit(4); // East and South together.
    nextCycle();
    @(negedge clk);
    checks++;
    assert (grant == portBit(2))
    else
    begin
      errors++;
      $display("Error at %0t: grant %b, expected East from idle", $time, grant);
    end
    @(negedge clk); // Zero limit, so South follows at once.
    checks++;
    assert (grant == portBit(4))
    else
    begin
      errors++;
      $display("Error at %0t: grant %b, expected South after East", $time, grant);
    end
    nextCycle();
    req <= '0;
    repeat (3) nextCycle();
  endtask

  task automatic checkLoneHold(input int port, input int limit);
    int cycles;
    nextCycle();
    req            <= '0;
    flitId[port]   <= routerPkg::FLIT_HEADER;
    length[port]   <= LEN_W'(limit);
    nextCycle();
    flitId[port]   <= routerPkg::FLIT_BODY;
    req            <= portBit(port);
    @(negedge clk);
    measureHold(port, cycles);
    checkCycles(port, cycles, limit);
    checks++;
    assert (grant == '0)
    else
    begin
      errors++;
      $display("Error at %0t: grant %b, expected idle after expiry", $time, grant);
    end
    @(negedge clk);
    checks++;
    assert (grant == portBit(port))
    else
    begin
      errors++;
      $display("Error at %0t: grant %b, expected port %0d again", $time, grant, port);
    end
    nextCycle();
    req <= '0;
    repeat (3) nextCycle();
  endtask

  task automatic checkRotation();
    int cycles;
    nextCycle();
    req <= '0;
    for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
    begin
      dirLimit[p] = int'(nextRandom() % 32'd8);
      flitId[p]   <= routerPkg::FLIT_HEADER;
      length[p]   <= LEN_W'(dirLimit[p]);
    end
    nextCycle();
    for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
    begin
      flitId[p] <= routerPkg::FLIT_BODY;
    end
    req <= '1;
    @(negedge clk);
    for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
    begin
      if (p > 0)
      begin
        checks++;
        assert (grant == portBit(p))
        else
        begin
          errors++;
          $display("Error at %0t: grant %b, expected port %0d in rotation", $time, grant, p);
        end
      end
      measureHold(p, cycles);
      checkCycles(p, cycles, dirLimit[p]);
    end
    nextCycle();
    req <= '0;
    repeat (3) nextCycle();
  endtask

  task automatic runRandom();
    logic [31:0] r;
    repeat (RANDOM_CYCLES)
    begin
      nextCycle();
      for (int p = 0; p < `ROUTER_NUM_PORTS; p++)
      begin
        r = nextRandom();
        req[p] <= (r[1:0] != 2'b00); // Mostly busy so holds build up.
        if (r[6:4] == 3'd0)
          flitId[p] <= routerPkg::FLIT_HEADER;
        else if (r[7])
          flitId[p] <= routerPkg::FLIT_TAIL;
        else
          flitId[p] <= routerPkg::FLIT_BODY;
        length[p] <= LEN_W'(r[11:8]);
      end
    end
  endtask

  initial
  begin
    rngState = 32'h58b1d95e;
    rst      <= 1'b1;
    req      <= '0;
    flitId   <= '0;
    length   <= '0;
    data     <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    checkResetAndPriority();
    for (int n = 0; n < 3; n++)
    begin
      checkLoneHold(int'(nextRandom() % 32'd5), int'(nextRandom() % 32'd8));
    end
    checkRotation();
    checkRotation();
    runRandom();
    repeat (2) nextCycle(); // Last stimulus is checked before the summary.

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
verilog/routerPkg.sv
verilog/timerIf.sv
verilog/packetTimer.sv
verilog/outputArbiter.sv
verilog/flitSwitch.sv
verilog/routerOutputPort.sv
bench/routerOutputPortTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f flist.f --top-module routerOutputPortTb \
  && ./obj_dir/VrouterOutputPortTb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
